//--- mips_core.f
+incdir+include
source/mips_pkg.sv
source/main_dec.sv
source/alu_dec.sv
source/controller.sv
source/reg_file.sv
source/alu.sv
source/datapath.sv
source/mips_core.sv
bench/tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mips_pkg.sv
      - source/main_dec.sv
      - source/alu_dec.sv
      - source/controller.sv
      - source/reg_file.sv
      - source/alu.sv
      - source/datapath.sv
      - source/mips_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_mips_core.sv

//--- bench/tb_mips_core.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_mips_core import mips_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 1;
    localparam int SEED         = 24161;

    logic               clk_i;
    logic               rst_n_i;
    logic [`DATA_W-1:0] instr_i;
    logic [`DATA_W-1:0] mem_rdata_i;
    logic [`DATA_W-1:0] pc_o;
    logic [`DATA_W-1:0] mem_addr_o;
    logic [`DATA_W-1:0] mem_wdata_o;
    logic               mem_we_o;

    // Memory models indexed by word address bits 9:2
    logic [`DATA_W-1:0] imem [256];
    logic [`DATA_W-1:0] dmem [256];
    // Reference state for expected values
    logic [`DATA_W-1:0] ref_dmem [256];
    logic [`DATA_W-1:0] ref_regs [`REG_COUNT];
    logic [`DATA_W-1:0] ref_pc;

    // Program table
    string              row_name [$];
    logic [`DATA_W-1:0] row_instr [$];
    logic [`DATA_W-1:0] row_pc [$];
    logic               row_we [$];
    logic [`DATA_W-1:0] row_addr [$];
    logic [`DATA_W-1:0] row_data [$];
    int                 row_count;
    int                 errors;

    mips_core i_mips_core (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .instr_i     (instr_i),
        .mem_rdata_i (mem_rdata_i),
        .pc_o        (pc_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_we_o    (mem_we_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Data memory with async read and edge store
    assign mem_rdata_i = dmem[mem_addr_o[9:2]];

    always @(posedge clk_i) begin
        if (mem_we_o) begin
            dmem[mem_addr_o[9:2]] <= mem_wdata_o;
        end
    end

    ////////////////////
    // Encoders
    ////////////////////

    function automatic logic [31:0] enc_i(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    // Preload pattern over the full word index
    function automatic logic [31:0] fill_word(int idx);
        return 32'hC0DE_0000 ^ (idx * 32'h0001_0101);
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    // Applies one instruction to the reference state and appends a row
    task automatic add_row(input string name, input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        we;
        a       = ref_regs[instr[25:21]];
        b       = ref_regs[instr[20:16]];
        imm     = {{16{instr[15]}}, instr[15:0]};
        res     = a + imm;
        next_pc = ref_pc + 32'd4;
        we      = 1'b0;
        case (instr[31:26])
            OP_RTYPE: begin
                case (instr[5:0])
                    6'h22:   res = a - b;
                    6'h24:   res = a & b;
                    6'h25:   res = a | b;
                    6'h2A:   res = {31'd0, $signed(a) < $signed(b)};
                    default: res = a + b;
                endcase
                ref_regs[instr[15:11]] = res;
            end
            OP_ADDI: ref_regs[instr[20:16]] = res;
            OP_LW:   ref_regs[instr[20:16]] = ref_dmem[res[9:2]];
            OP_SW: begin
                we = 1'b1;
                ref_dmem[res[9:2]] = b;
            end
            // Offset counts words from pc + 4
            OP_BEQ:  if (a == b) next_pc = next_pc + (imm << 2);
            OP_J:    next_pc = {next_pc[31:28], instr[25:0], 2'b00};
            default: ;
        endcase
        ref_regs[0] = '0;
        row_name.push_back(name);
        row_instr.push_back(instr);
        row_pc.push_back(ref_pc);
        row_we.push_back(we);
        row_addr.push_back(res);
        row_data.push_back(b);
        ref_pc = next_pc;
    endtask

    task automatic build_program();
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] r3;
        // r2 ends up positive and r3 negative for the signed compare
        r1 = {1'b0, 15'($urandom())} | 16'h0001;
        r2 = {1'b0, 15'($urandom())};
        r3 = {1'b1, 15'($urandom())};
        add_row("addi_r1", enc_i(OP_ADDI, 0, 1, r1));
        add_row("addi_r2", enc_i(OP_ADDI, 1, 2, r2));
        add_row("sw_sum", enc_i(OP_SW, 1, 2, 16'h0008));
        add_row("addi_r3", enc_i(OP_ADDI, 0, 3, r3));
        add_row("add", enc_r(2, 3, 4, 6'h20));
        add_row("sw_add", enc_i(OP_SW, 0, 4, 16'h0004));
        add_row("sub", enc_r(2, 3, 5, 6'h22));
        add_row("sw_sub", enc_i(OP_SW, 0, 5, 16'h0008));
        add_row("and", enc_r(2, 3, 6, 6'h24));
        add_row("sw_and", enc_i(OP_SW, 0, 6, 16'h000C));
        add_row("or", enc_r(2, 3, 7, 6'h25));
        add_row("sw_or", enc_i(OP_SW, 0, 7, 16'h0010));
        add_row("slt_23", enc_r(2, 3, 8, 6'h2A));
        add_row("sw_slt_23", enc_i(OP_SW, 0, 8, 16'h0014));
        add_row("slt_32", enc_r(3, 2, 9, 6'h2A));
        add_row("sw_slt_32", enc_i(OP_SW, 0, 9, 16'h0018));
        // Preloaded word copied to a second address
        add_row("lw", enc_i(OP_LW, 0, 10, 16'h0100));
        add_row("sw_lw", enc_i(OP_SW, 0, 10, 16'h001C));
        add_row("beq_taken", enc_i(OP_BEQ, 1, 1, 16'h0002));
        add_row("beq_not_taken", enc_i(OP_BEQ, 2, 3, 16'hFFF0));
        add_row("j", {OP_J, 26'h40});
        add_row("addi_zero", enc_i(OP_ADDI, 0, 0, r1));
        add_row("sw_zero", enc_i(OP_SW, 0, 0, 16'h0020));
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error %s %s: expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        clk_i   = 1'b0;
        rst_n_i = 1'b0;
        // Stray store during reset must not reach memory
        instr_i = enc_i(OP_SW, 0, 0, 16'h0000);
        errors  = 0;
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            imem[i]     = '0;
            dmem[i]     = fill_word(i);
            ref_dmem[i] = fill_word(i);
        end
        foreach (ref_regs[i]) ref_regs[i] = '0;
        ref_pc = `RESET_PC;
        build_program();
        row_count = row_name.size();

        repeat (RESET_CYCLES) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            check_value("reset", "pc", `RESET_PC, pc_o);
            check_value("reset", "mem_we", 32'(1'b0), 32'(mem_we_o));
        end
        rst_n_i = 1'b1;

        for (int i = 0; i < row_count; i++) begin
            imem[row_pc[i][9:2]] = row_instr[i];
            instr_i = imem[pc_o[9:2]];
            @(negedge clk_i);
            check_value(row_name[i], "pc", row_pc[i], pc_o);
            check_value(row_name[i], "mem_we", 32'(row_we[i]), 32'(mem_we_o));
            if (row_we[i]) begin
                check_value(row_name[i], "store addr", row_addr[i], mem_addr_o);
                check_value(row_name[i], "store data", row_data[i], mem_wdata_o);
            end
            @(posedge clk_i);
            #DRIVE_DELAY;
        end

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (row_count > 0);
        #((row_count + 20) * CLK_PERIOD);
        $display("Timeout: program did not finish within %0d cycles", row_count + 20);
        $display("Test failed");
        $finish;
    end

endmodule

//--- source/mips_core.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core import mips_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [`DATA_W-1:0] instr_i,
    input  logic [`DATA_W-1:0] mem_rdata_i,
    output logic [`DATA_W-1:0] pc_o,
    output logic [`DATA_W-1:0] mem_addr_o,
    output logic [`DATA_W-1:0] mem_wdata_o,
    output logic               mem_we_o
);

    ctrl_t ctrl;
    logic  zero;

    ////////////////////
    // Decode
    ////////////////////

    controller i_controller (
        .op_i    (opcode_e'(instr_i[31:26])),
        .funct_i (instr_i[5:0]),
        .zero_i  (zero),
        .ctrl_o  (ctrl)
    );

    ////////////////////
    // Execute
    ////////////////////

    datapath i_datapath (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .instr_i     (instr_i),
        .ctrl_i      (ctrl),
        .mem_rdata_i (mem_rdata_i),
        .pc_o        (pc_o),
        .alu_y_o     (mem_addr_o),
        .wdata_o     (mem_wdata_o),
        .zero_o      (zero)
    );

    // No stores while reset is held
    assign mem_we_o = ctrl.mem_write & rst_n_i;

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module datapath import mips_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [`DATA_W-1:0] instr_i,
    input  ctrl_t              ctrl_i,
    input  logic [`DATA_W-1:0] mem_rdata_i,
    output logic [`DATA_W-1:0] pc_o,
    output logic [`DATA_W-1:0] alu_y_o,
    output logic [`DATA_W-1:0] wdata_o,
    output logic               zero_o
);

    logic [`DATA_W-1:0]     pc_q;
    logic [`DATA_W-1:0]     pc_next;
    logic [`DATA_W-1:0]     pc_plus4;
    logic [`DATA_W-1:0]     pc_branch_tgt;
    logic [`DATA_W-1:0]     pc_jump_tgt;
    logic [`DATA_W-1:0]     imm_ext;
    logic [`DATA_W-1:0]     rd1;
    logic [`DATA_W-1:0]     rd2;
    logic [`DATA_W-1:0]     alu_b;
    logic [`DATA_W-1:0]     wb_data;
    logic [`REG_ADDR_W-1:0] wa;

    ////////////////////
    // Program counter
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_plus4      = pc_q + `DATA_W'd4;
    // Word offset relative to the delay slot address
    assign pc_branch_tgt = pc_plus4 + {imm_ext[`DATA_W-3:0], 2'b00};
    // Region bits kept from pc+4
    assign pc_jump_tgt   = {pc_plus4[31:28], instr_i[25:0], 2'b00};

    // Jump beats branch beats sequential
    always_comb begin
        if (ctrl_i.pc_jump) begin
            pc_next = pc_jump_tgt;
        end else if (ctrl_i.pc_branch) begin
            pc_next = pc_branch_tgt;
        end else begin
            pc_next = pc_plus4;
        end
    end

    ////////////////////
    // Operands
    ////////////////////

    // Sign extend imm16
    assign imm_ext = {{(`DATA_W-16){instr_i[15]}}, instr_i[15:0]};

    // rd for R-type, rt otherwise
    assign wa = ctrl_i.reg_dst_rd ? instr_i[15:11] : instr_i[20:16];

    reg_file i_reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (ctrl_i.reg_write),
        .ra1_i   (instr_i[25:21]),
        .ra2_i   (instr_i[20:16]),
        .wa_i    (wa),
        .wd_i    (wb_data),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    assign alu_b = ctrl_i.alu_src_imm ? imm_ext : rd2;

    alu i_alu (
        .a_i    (rd1),
        .b_i    (alu_b),
        .ctrl_i (ctrl_i.alu_ctrl),
        .y_o    (alu_y_o),
        .zero_o (zero_o)
    );

    // Load data or ALU result
    assign wb_data = ctrl_i.mem_to_reg ? mem_rdata_i : alu_y_o;

    assign pc_o    = pc_q;
    // Store data is always rt
    assign wdata_o = rd2;

endmodule

//--- source/alu.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module alu import mips_pkg::*; (
    input  logic [`DATA_W-1:0] a_i,
    input  logic [`DATA_W-1:0] b_i,
    input  alu_ctrl_e          ctrl_i,
    output logic [`DATA_W-1:0] y_o,
    output logic               zero_o
);

    // Signed compare for slt
    logic a_lt_b;

    assign a_lt_b = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (ctrl_i)
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            // Zero extended compare result
            ALU_SLT: y_o = {{(`DATA_W-1){1'b0}}, a_lt_b};
            default: y_o = '0;
        endcase
    end

    // Used by beq
    assign zero_o = (y_o == '0);

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module reg_file (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] ra1_i,
    input  logic [`REG_ADDR_W-1:0] ra2_i,
    input  logic [`REG_ADDR_W-1:0] wa_i,
    input  logic [`DATA_W-1:0]     wd_i,
    output logic [`DATA_W-1:0]     rd1_o,
    output logic [`DATA_W-1:0]     rd2_o
);

    // Storage array
    logic [`DATA_W-1:0] regs [`REG_COUNT];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk_i) begin
        // Blocked while reset is held
        if (rst_n_i && we_i) begin
            regs[wa_i] <= wd_i;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    // $zero never reflects a write
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

    // Word written on one edge reads back in the next cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($past(rst_n_i && we_i && wa_i != '0) && ra1_i == $past(wa_i))
            |-> (rd1_o == $past(wd_i)))
        else $error("reg_file: written word did not read back");

endmodule

//--- source/controller.sv
`timescale 1ns/1ps

module controller import mips_pkg::*; (
    input  opcode_e    op_i,
    input  logic [5:0] funct_i,
    input  logic       zero_i,
    output ctrl_t      ctrl_o
);

    ctrl_t     dec_ctrl;
    logic      branch;
    alu_op_e   alu_op;
    alu_ctrl_e alu_ctrl;

    // Opcode level decode
    main_dec i_main_dec (
        .op_i     (op_i),
        .ctrl_o   (dec_ctrl),
        .branch_o (branch),
        .alu_op_o (alu_op)
    );

    // Function field decode
    alu_dec i_alu_dec (
        .alu_op_i   (alu_op),
        .funct_i    (funct_i),
        .alu_ctrl_o (alu_ctrl)
    );

    ////////////////////
    // Merge
    ////////////////////

    always_comb begin
        ctrl_o           = dec_ctrl;
        // beq only taken on equal operands
        ctrl_o.pc_branch = branch & zero_i;
        ctrl_o.alu_ctrl  = alu_ctrl;
    end

    // Branch and jump are exclusive in the next-PC mux
    assert property (@(ctrl_o) !(ctrl_o.pc_branch && ctrl_o.pc_jump))
        else $error("controller: pc_branch and pc_jump both set");

endmodule

//--- source/alu_dec.sv
`timescale 1ns/1ps

module alu_dec import mips_pkg::*; (
    input  alu_op_e     alu_op_i,
    input  logic [5:0]  funct_i,
    output alu_ctrl_e   alu_ctrl_o
);

    always_comb begin
        case (alu_op_i)
            // Address calc and addi
            ALUOP_ADD: alu_ctrl_o = ALU_ADD;
            // beq compare
            ALUOP_SUB: alu_ctrl_o = ALU_SUB;
            ALUOP_FUNCT: begin
                // R-type function field
                case (funct_i)
                    6'h20:   alu_ctrl_o = ALU_ADD;
                    6'h22:   alu_ctrl_o = ALU_SUB;
                    6'h24:   alu_ctrl_o = ALU_AND;
                    6'h25:   alu_ctrl_o = ALU_OR;
                    6'h2A:   alu_ctrl_o = ALU_SLT;
                    // Unsupported functs treated as add
                    default: alu_ctrl_o = ALU_ADD;
                endcase
            end
            default: alu_ctrl_o = ALU_ADD;
        endcase
    end

endmodule

//--- source/main_dec.sv
`timescale 1ns/1ps

module main_dec import mips_pkg::*; (
    input  opcode_e op_i,
    output ctrl_t   ctrl_o,
    output logic    branch_o,
    output alu_op_e alu_op_o
);

    // Level decode of the primary opcode
    always_comb begin
        // Unknown opcodes fall through as a no-op
        ctrl_o   = '0;
        branch_o = 1'b0;
        alu_op_o = ALUOP_ADD;

        case (op_i)
            OP_RTYPE: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.reg_dst_rd = 1'b1;
                alu_op_o          = ALUOP_FUNCT;
            end
            OP_LW: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_to_reg  = 1'b1;
            end
            OP_SW: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
            end
            OP_BEQ: begin
                // Subtraction compare gated later by the zero flag
                branch_o = 1'b1;
                alu_op_o = ALUOP_SUB;
            end
            OP_ADDI: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
            end
            OP_J: begin
                ctrl_o.pc_jump = 1'b1;
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

endmodule

//--- source/mips_pkg.sv
package mips_pkg;

    ////////////////////
    // Primary opcodes
    ////////////////////

    // Encodings from instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // Class of ALU work picked by the main decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_FUNCT = 2'b10
    } alu_op_e;

    // Operation actually performed by the ALU
    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } alu_ctrl_e;

    ////////////////////
    // Control word
    ////////////////////

    typedef struct packed {
        logic      mem_to_reg;   // Write back load data
        logic      mem_write;    // Data memory store strobe
        logic      pc_branch;    // Branch taken
        logic      alu_src_imm;  // ALU b from immediate
        logic      reg_dst_rd;   // Destination rd, else rt
        logic      reg_write;    // Register file write enable
        logic      pc_jump;      // Jump taken
        alu_ctrl_e alu_ctrl;
    } ctrl_t;

endpackage

//--- include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

////////////////////
// Core widths
////////////////////

// Word, address and register width
`define DATA_W 32

// Register index width, five bits for rs, rt and rd
`define REG_ADDR_W 5

// Number of architectural registers
`define REG_COUNT (1 << `REG_ADDR_W)

////////////////////
// Reset state
////////////////////

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
